/* source/rv_isa_pkg.sv */
// RV64 instruction-set constants and register/address types, imported by decode and datapaths
`default_nettype none

package rv_isa_pkg;

    typedef logic [63:0] xlen_t;     // register value
    typedef logic [31:0] word_t;     // W-form operand and instruction word
    typedef logic [63:0] addr_t;     // pc and memory address
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // major opcodes
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_IMM_32 = 7'b0011011;
    localparam opcode_t OP        = 7'b0110011;
    localparam opcode_t OP_32     = 7'b0111011;
    localparam opcode_t LUI       = 7'b0110111;
    localparam opcode_t AUIPC     = 7'b0010111;
    localparam opcode_t JAL       = 7'b1101111;
    localparam opcode_t JALR      = 7'b1100111;
    localparam opcode_t BRANCH    = 7'b1100011;
    localparam opcode_t LOAD      = 7'b0000011;
    localparam opcode_t STORE     = 7'b0100011;
    localparam opcode_t SYSTEM    = 7'b1110011;

    // integer functions
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_MUL     = 3'b000;

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // loads and stores, low two bits give the size
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LD  = 3'b011;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;
    localparam funct3_t F3_LWU = 3'b110;
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SH  = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;
    localparam funct3_t F3_SD  = 3'b011;

    localparam funct7_t F7_BASE   = 7'b0000000;
    localparam funct7_t F7_ALT    = 7'b0100000;  // sub and arithmetic shifts
    localparam funct7_t F7_MULDIV = 7'b0000001;

endpackage

`default_nettype wire

/* source/exec_pkg.sv */
// execute-stage internal encodings shared by the control block and the datapath units
`default_nettype none

package exec_pkg;

    typedef logic [3:0] alu_op_t;
    typedef logic [1:0] mem_size_t;
    typedef logic [1:0] res_sel_t;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    localparam alu_op_t ALU_MUL    = 4'd10;
    localparam alu_op_t ALU_PASS_B = 4'd11;   // lui

    // matches funct3[1:0] of loads and stores
    localparam mem_size_t SIZE_B = 2'd0;
    localparam mem_size_t SIZE_H = 2'd1;
    localparam mem_size_t SIZE_W = 2'd2;
    localparam mem_size_t SIZE_D = 2'd3;

    localparam res_sel_t RES_ALU  = 2'd0;
    localparam res_sel_t RES_LINK = 2'd1;
    localparam res_sel_t RES_NONE = 2'd2;   // no write-back

endpackage

`default_nettype wire

/* source/exec_bus_if.sv */
// operand and result bundle between the execute control block and its datapath units
`default_nettype none

interface exec_bus_if;
    import rv_isa_pkg::*;
    import exec_pkg::*;

    // driven by control
    xlen_t   rs1_val;
    xlen_t   rs2_val;
    xlen_t   imm;
    addr_t   pc;
    funct3_t funct3;
    alu_op_t alu_op;
    logic    use_imm;
    logic    use_pc;     // auipc takes pc as operand a
    logic    word_op;
    logic    jalr;

    // driven by the datapath units
    xlen_t     alu_result;
    logic      br_taken;
    addr_t     br_target;
    xlen_t     link_val;
    addr_t     mem_addr;
    xlen_t     store_data;
    mem_size_t mem_size;

    modport ctrl (
        output rs1_val, rs2_val, imm, pc, funct3, alu_op, use_imm, use_pc, word_op, jalr,
        input  alu_result, br_taken, br_target, link_val, mem_addr, store_data, mem_size
    );

    modport alu (
        input  rs1_val, rs2_val, imm, pc, alu_op, use_imm, use_pc, word_op,
        output alu_result
    );

    modport br (
        input  rs1_val, rs2_val, imm, pc, funct3, jalr,
        output br_taken, br_target, link_val
    );

    modport agu (
        input  rs1_val, rs2_val, imm, funct3,
        output mem_addr, store_data, mem_size
    );

endinterface

`default_nettype wire

/* source/exec_control.sv */
// decodes the instruction word, steers the datapath units and registers every stage output
`default_nettype none

module exec_control (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               i_valid,
    input  wire logic               i_flush,
    input  wire rv_isa_pkg::word_t  i_inst,
    input  wire rv_isa_pkg::addr_t  i_pc,
    input  wire rv_isa_pkg::xlen_t  i_rs1_value,
    input  wire rv_isa_pkg::xlen_t  i_rs2_value,
    exec_bus_if.ctrl                bus,
    output logic                    o_wr_en,
    output rv_isa_pkg::reg_idx_t    o_rd,
    output rv_isa_pkg::xlen_t       o_result,
    output logic                    o_load,
    output logic                    o_store,
    output rv_isa_pkg::addr_t       o_mem_addr,
    output rv_isa_pkg::xlen_t       o_store_data,
    output exec_pkg::mem_size_t     o_mem_size,
    output logic                    o_jmp,
    output rv_isa_pkg::addr_t       o_jmp_target,
    output logic                    o_ecall,
    output rv_isa_pkg::addr_t       o_pc
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    opcode_t  opcode;
    reg_idx_t rd;
    funct3_t  funct3;
    funct7_t  funct7;
    xlen_t    imm_i, imm_s, imm_b, imm_u, imm_j;
    xlen_t    imm;
    alu_op_t  alu_op;
    res_sel_t res_sel;
    logic     use_imm, use_pc, word_op, jalr;
    logic     is_load, is_store, is_jump, is_branch, is_ecall;
    logic     alt_imm, w_legal;
    logic     fire, wr_d, jmp_d;

    function automatic alu_op_t funct_to_op(input funct3_t f3, input logic alt);
        case (f3)
            F3_ADD_SUB: funct_to_op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     funct_to_op = ALU_SLL;
            F3_SLT:     funct_to_op = ALU_SLT;
            F3_SLTU:    funct_to_op = ALU_SLTU;
            F3_XOR:     funct_to_op = ALU_XOR;
            F3_SRL_SRA: funct_to_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      funct_to_op = ALU_OR;
            default:    funct_to_op = ALU_AND;
        endcase
    endfunction

    assign opcode = i_inst[6:0];
    assign rd     = i_inst[11:7];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
    assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    // immediate forms only see the alt bit on right shifts
    assign alt_imm = (funct3 == F3_SRL_SRA) && funct7[5];
    assign w_legal = (funct3 == F3_ADD_SUB) || (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);

    always_comb begin
        alu_op    = ALU_ADD;
        res_sel   = RES_NONE;
        imm       = imm_i;
        use_imm   = 1'b0;
        use_pc    = 1'b0;
        word_op   = 1'b0;
        jalr      = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_jump   = 1'b0;
        is_branch = 1'b0;
        is_ecall  = 1'b0;
        case (opcode)
            OP_IMM: begin
                use_imm = 1'b1;
                alu_op  = funct_to_op(funct3, alt_imm);
                res_sel = RES_ALU;
            end
            OP_IMM_32: begin
                use_imm = 1'b1;
                word_op = 1'b1;
                alu_op  = funct_to_op(funct3, alt_imm);
                res_sel = w_legal ? RES_ALU : RES_NONE;
            end
            OP, OP_32: begin
                word_op = (opcode == OP_32);
                if (funct7 == F7_MULDIV) begin
                    alu_op  = ALU_MUL;
                    res_sel = (funct3 == F3_MUL) ? RES_ALU : RES_NONE;   // div/rem/mulh dropped
                end else if (funct7 == F7_BASE || funct7 == F7_ALT) begin
                    alu_op  = funct_to_op(funct3, funct7 == F7_ALT);
                    res_sel = (opcode == OP || w_legal) ? RES_ALU : RES_NONE;
                end
            end
            LUI: begin
                imm     = imm_u;
                use_imm = 1'b1;
                alu_op  = ALU_PASS_B;
                res_sel = RES_ALU;
            end
            AUIPC: begin
                imm     = imm_u;
                use_imm = 1'b1;
                use_pc  = 1'b1;
                res_sel = RES_ALU;
            end
            JAL: begin
                imm     = imm_j;
                is_jump = 1'b1;
                res_sel = RES_LINK;
            end
            JALR: begin
                jalr    = 1'b1;
                is_jump = 1'b1;
                res_sel = RES_LINK;
            end
            BRANCH: begin
                imm       = imm_b;
                is_branch = 1'b1;
            end
            LOAD: begin
                use_imm = 1'b1;   // result carries the address, rd goes on to memory
                is_load = 1'b1;
                res_sel = RES_ALU;
            end
            STORE: begin
                imm      = imm_s;
                is_store = 1'b1;
            end
            SYSTEM: is_ecall = (funct3 == 3'b000) && (imm_i == '0);
            default: ;   // unknown opcode, no-op
        endcase
    end

    assign bus.rs1_val = i_rs1_value;
    assign bus.rs2_val = i_rs2_value;
    assign bus.imm     = imm;
    assign bus.pc      = i_pc;
    assign bus.funct3  = funct3;
    assign bus.alu_op  = alu_op;
    assign bus.use_imm = use_imm;
    assign bus.use_pc  = use_pc;
    assign bus.word_op = word_op;
    assign bus.jalr    = jalr;

    assign fire  = i_valid && !i_flush;
    assign wr_d  = fire && (res_sel != RES_NONE) && (rd != '0);   // x0 never written
    assign jmp_d = fire && (is_jump || (is_branch && bus.br_taken));

    always_ff @(posedge clk) begin
        if (reset) begin
            o_wr_en <= 1'b0;
            o_rd    <= '0;
            o_load  <= 1'b0;
            o_store <= 1'b0;
            o_jmp   <= 1'b0;
            o_ecall <= 1'b0;
            o_pc    <= '0;
        end else begin
            o_wr_en <= wr_d;
            o_rd    <= wr_d ? rd : '0;
            o_load  <= fire && is_load;
            o_store <= fire && is_store;
            o_jmp   <= jmp_d;
            o_ecall <= fire && is_ecall;
            o_pc    <= i_pc;
        end
    end

    always_ff @(posedge clk) begin
        o_result     <= (res_sel == RES_LINK) ? bus.link_val : bus.alu_result;
        o_mem_addr   <= bus.mem_addr;
        o_store_data <= bus.store_data;
        o_mem_size   <= bus.mem_size;
        o_jmp_target <= bus.br_target;
    end

endmodule

`default_nettype wire

/* source/int_alu.sv */
// combinational integer ALU for the execute stage, 64-bit and W forms including low multiply
`default_nettype none

module int_alu (
    exec_bus_if.alu bus
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    xlen_t      op_a;
    xlen_t      op_b;
    logic [5:0] shamt;
    word_t      a_w;
    word_t      b_w;
    xlen_t      res_d;
    word_t      res_w;

    assign op_a  = bus.use_pc ? bus.pc : bus.rs1_val;
    assign op_b  = bus.use_imm ? bus.imm : bus.rs2_val;
    assign shamt = op_b[5:0];
    assign a_w   = op_a[31:0];
    assign b_w   = op_b[31:0];

    // full width
    always_comb begin
        case (bus.alu_op)
            ALU_ADD:    res_d = op_a + op_b;
            ALU_SUB:    res_d = op_a - op_b;
            ALU_SLL:    res_d = op_a << shamt;
            ALU_SLT:    res_d = xlen_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   res_d = xlen_t'(op_a < op_b);
            ALU_XOR:    res_d = op_a ^ op_b;
            ALU_SRL:    res_d = op_a >> shamt;
            ALU_SRA:    res_d = $signed(op_a) >>> shamt;
            ALU_OR:     res_d = op_a | op_b;
            ALU_AND:    res_d = op_a & op_b;
            ALU_MUL:    res_d = op_a * op_b;   // low 64 bits
            ALU_PASS_B: res_d = op_b;
            default:    res_d = '0;
        endcase
    end

    // word forms work on the low halves only
    always_comb begin
        case (bus.alu_op)
            ALU_ADD: res_w = a_w + b_w;
            ALU_SUB: res_w = a_w - b_w;
            ALU_SLL: res_w = a_w << shamt[4:0];
            ALU_SRL: res_w = a_w >> shamt[4:0];
            ALU_SRA: res_w = $signed(a_w) >>> shamt[4:0];
            ALU_MUL: res_w = a_w * b_w;
            default: res_w = res_d[31:0];
        endcase
    end

    assign bus.alu_result = bus.word_op ? {{32{res_w[31]}}, res_w} : res_d;

endmodule

`default_nettype wire

/* source/branch_unit.sv */
// combinational branch compare, jump and branch target and link value for the execute stage
`default_nettype none

module branch_unit (
    exec_bus_if.br bus
);
    import rv_isa_pkg::*;

    addr_t base;
    addr_t sum;

    always_comb begin
        case (bus.funct3)
            F3_BEQ:  bus.br_taken = (bus.rs1_val == bus.rs2_val);
            F3_BNE:  bus.br_taken = (bus.rs1_val != bus.rs2_val);
            F3_BLT:  bus.br_taken = ($signed(bus.rs1_val) < $signed(bus.rs2_val));
            F3_BGE:  bus.br_taken = ($signed(bus.rs1_val) >= $signed(bus.rs2_val));
            F3_BLTU: bus.br_taken = (bus.rs1_val < bus.rs2_val);
            F3_BGEU: bus.br_taken = (bus.rs1_val >= bus.rs2_val);
            default: bus.br_taken = 1'b0;
        endcase
    end

    assign base = bus.jalr ? bus.rs1_val : bus.pc;
    assign sum  = base + bus.imm;

    // jalr drops bit 0 of the sum
    assign bus.br_target = bus.jalr ? {sum[63:1], 1'b0} : sum;
    assign bus.link_val  = bus.pc + 64'd4;

endmodule

`default_nettype wire

/* source/mem_agu.sv */
// combinational load/store address generation and store-data sizing for the execute stage
`default_nettype none

module mem_agu (
    exec_bus_if.agu bus
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    mem_size_t size;

    assign size         = mem_size_t'(bus.funct3[1:0]);  // unsigned loads share the size bits
    assign bus.mem_size = size;
    assign bus.mem_addr = bus.rs1_val + bus.imm;

    // zero-extended, upper bytes cleared
    always_comb begin
        case (size)
            SIZE_B:  bus.store_data = xlen_t'(bus.rs2_val[7:0]);
            SIZE_H:  bus.store_data = xlen_t'(bus.rs2_val[15:0]);
            SIZE_W:  bus.store_data = xlen_t'(bus.rs2_val[31:0]);
            SIZE_D:  bus.store_data = bus.rs2_val;
            default: bus.store_data = bus.rs2_val;
        endcase
    end

endmodule

`default_nettype wire

/* source/exec_stage.sv */
// RV64IM execute stage top level, one-cycle registered result from a raw instruction word
`default_nettype none

module exec_stage (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               i_valid,
    input  wire logic               i_flush,
    input  wire rv_isa_pkg::word_t  i_inst,
    input  wire rv_isa_pkg::addr_t  i_pc,
    input  wire rv_isa_pkg::xlen_t  i_rs1_value,
    input  wire rv_isa_pkg::xlen_t  i_rs2_value,
    output logic                    o_wr_en,
    output rv_isa_pkg::reg_idx_t    o_rd,
    output rv_isa_pkg::xlen_t       o_result,
    output logic                    o_load,
    output logic                    o_store,
    output rv_isa_pkg::addr_t       o_mem_addr,
    output rv_isa_pkg::xlen_t       o_store_data,
    output exec_pkg::mem_size_t     o_mem_size,
    output logic                    o_jmp,
    output rv_isa_pkg::addr_t       o_jmp_target,
    output logic                    o_ecall,
    output rv_isa_pkg::addr_t       o_pc
);

    exec_bus_if bus ();

    exec_control i_exec_control (
        .clk          (clk),
        .reset        (reset),
        .i_valid      (i_valid),
        .i_flush      (i_flush),
        .i_inst       (i_inst),
        .i_pc         (i_pc),
        .i_rs1_value  (i_rs1_value),
        .i_rs2_value  (i_rs2_value),
        .bus          (bus.ctrl),
        .o_wr_en      (o_wr_en),
        .o_rd         (o_rd),
        .o_result     (o_result),
        .o_load       (o_load),
        .o_store      (o_store),
        .o_mem_addr   (o_mem_addr),
        .o_store_data (o_store_data),
        .o_mem_size   (o_mem_size),
        .o_jmp        (o_jmp),
        .o_jmp_target (o_jmp_target),
        .o_ecall      (o_ecall),
        .o_pc         (o_pc)
    );

    // datapath units, all combinational
    int_alu     i_int_alu     (.bus(bus.alu));
    branch_unit i_branch_unit (.bus(bus.br));
    mem_agu     i_mem_agu     (.bus(bus.agu));

endmodule

`default_nettype wire

/* dv/exec_stage_checker.sv */
// output protocol assertions for the execute stage, bound into exec_stage by the bind below
`default_nettype none

module exec_stage_checker (
    input wire logic                 clk,
    input wire logic                 reset,
    input wire logic                 i_valid,
    input wire logic                 i_flush,
    input wire logic                 o_wr_en,
    input wire rv_isa_pkg::reg_idx_t o_rd,
    input wire logic                 o_load,
    input wire logic                 o_store,
    input wire logic                 o_jmp,
    input wire rv_isa_pkg::addr_t    o_jmp_target,
    input wire logic                 o_ecall
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;   // read by the testbench at the end

    load_store_excl: assert property (@(posedge clk) disable iff (reset) !(o_load && o_store))
        else begin
            fail_count++;
            $error("o_load and o_store are high in the same cycle");
        end

    rd_zero_no_write: assert property (@(posedge clk) disable iff (reset) !o_wr_en |-> o_rd == '0)
        else begin
            fail_count++;
            $error("o_rd is not zero while o_wr_en is low");
        end

    target_aligned: assert property (@(posedge clk) disable iff (reset) o_jmp |-> !o_jmp_target[0])
        else begin
            fail_count++;
            $error("o_jmp_target has bit 0 set on a jump");
        end

    // a dropped instruction leaves no control output behind
    dropped_quiet: assert property (@(posedge clk) disable iff (reset)
        (!i_valid || i_flush) |=> !(o_wr_en || o_load || o_store || o_jmp || o_ecall))
        else begin
            fail_count++;
            $error("control output high the cycle after a flushed or invalid input");
        end

endmodule

bind exec_stage exec_stage_checker i_exec_stage_checker (
    .clk          (clk),
    .reset        (reset),
    .i_valid      (i_valid),
    .i_flush      (i_flush),
    .o_wr_en      (o_wr_en),
    .o_rd         (o_rd),
    .o_load       (o_load),
    .o_store      (o_store),
    .o_jmp        (o_jmp),
    .o_jmp_target (o_jmp_target),
    .o_ecall      (o_ecall)
);

`default_nettype wire

/* dv/exec_stage_tb.sv */
// directed testbench for the RV64IM execute stage, the simulation top with an RV64 reference model
`default_nettype none

module exec_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_isa_pkg::*;
    import exec_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int N_ITER          = 20;
    localparam int INSTS_PER_ITER  = 45;   // instructions issued per pass over the test tasks
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + N_ITER * INSTS_PER_ITER) + 200;

    localparam xlen_t    SIGN_BIT   = 64'h8000_0000_0000_0000;
    localparam reg_idx_t RS1_IDX    = 5'd10;
    localparam reg_idx_t RS2_IDX    = 5'd11;
    localparam word_t    ECALL_INST = 32'h0000_0073;

    logic      clk = 1'b0;
    logic      reset;
    logic      i_valid;
    logic      i_flush;
    word_t     i_inst;
    addr_t     i_pc;
    xlen_t     i_rs1_value;
    xlen_t     i_rs2_value;
    logic      o_wr_en;
    reg_idx_t  o_rd;
    xlen_t     o_result;
    logic      o_load;
    logic      o_store;
    addr_t     o_mem_addr;
    xlen_t     o_store_data;
    mem_size_t o_mem_size;
    logic      o_jmp;
    addr_t     o_jmp_target;
    logic      o_ecall;
    addr_t     o_pc;

    int          errors    = 0;
    int          checks    = 0;
    logic [63:0] lcg_state = 64'd38941;

    exec_stage i_exec_stage (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state[63:32];   // high half, low bits of an lcg repeat quickly
    endfunction

    function automatic xlen_t rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    function automatic addr_t rand_pc();
        xlen_t r;
        r = rand64();
        return {r[63:2], 2'b00};
    endfunction

    function automatic xlen_t sext(xlen_t v, int bits);
        xlen_t m;
        m = ~64'h0 << bits;
        return v[bits - 1] ? (v | m) : (v & ~m);
    endfunction

    function automatic xlen_t sra(xlen_t v, int sh);
        xlen_t fill;
        fill = v[63] ? ~(~64'h0 >> sh) : 64'h0;
        return (v >> sh) | fill;
    endfunction

    // instruction encoders, register index fields are fixed
    function automatic word_t enc_r(funct7_t f7, funct3_t f3, reg_idx_t rd, opcode_t op);
        return {f7, RS2_IDX, RS1_IDX, f3, rd, op};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, funct3_t f3, reg_idx_t rd, opcode_t op);
        return {imm, RS1_IDX, f3, rd, op};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, funct3_t f3);
        return {imm[11:5], RS2_IDX, RS1_IDX, f3, imm[4:0], STORE};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, funct3_t f3);
        return {imm[12], imm[10:5], RS2_IDX, RS1_IDX, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    // RV64 integer rules, W forms keep 32 bits and sign-extend bit 31
    function automatic xlen_t ref_alu(funct3_t f3, logic alt, logic word, xlen_t a, xlen_t b);
        if (word) begin
            case (f3)
                F3_ADD_SUB: return sext(alt ? a - b : a + b, 32);
                F3_SLL:     return sext(a << b[4:0], 32);
                default:    return alt ? sra(sext(a, 32), b[4:0]) : sext(a[31:0] >> b[4:0], 32);
            endcase
        end
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL:     return a << b[5:0];
            F3_SLT:     return {63'b0, (a ^ SIGN_BIT) < (b ^ SIGN_BIT)};
            F3_SLTU:    return {63'b0, a < b};
            F3_XOR:     return a ^ b;
            F3_SRL_SRA: return alt ? sra(a, b[5:0]) : a >> b[5:0];
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    function automatic logic ref_branch(funct3_t f3, xlen_t a, xlen_t b);
        logic lt;
        logic ltu;
        lt  = (a ^ SIGN_BIT) < (b ^ SIGN_BIT);
        ltu = a < b;
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return lt;
            F3_BGE:  return !lt;
            F3_BLTU: return ltu;
            default: return !ltu;
        endcase
    endfunction

    // drive 1 ns after an edge, return 1 ns after the next one with outputs settled
    task automatic step(word_t inst, addr_t pc, xlen_t a, xlen_t b, logic valid, logic flush);
        i_inst      = inst;
        i_pc        = pc;
        i_rs1_value = a;
        i_rs2_value = b;
        i_valid     = valid;
        i_flush     = flush;
        @(posedge clk);
        #1;
    endtask

    task automatic check_val(string name, xlen_t got, xlen_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_ctrl(logic wr, reg_idx_t rd, logic ld, logic st, logic jmp, logic ecall);
        check_val("o_wr_en", o_wr_en, wr);
        check_val("o_rd", o_rd, wr ? rd : 5'd0);
        check_val("o_load", o_load, ld);
        check_val("o_store", o_store, st);
        check_val("o_jmp", o_jmp, jmp);
        check_val("o_ecall", o_ecall, ecall);
    endtask

    task automatic check_write(string what, reg_idx_t rd, xlen_t exp, addr_t pc);
        check_ctrl(rd != 0, rd, 1'b0, 1'b0, 1'b0, 1'b0);
        check_val("o_pc", o_pc, pc);
        if (rd != 0)
            check_val({what, " o_result"}, o_result, exp);
    endtask

    task automatic check_jump(reg_idx_t rd, addr_t target, addr_t pc);
        check_ctrl(rd != 0, rd, 1'b0, 1'b0, 1'b1, 1'b0);
        check_val("o_jmp_target", o_jmp_target, target);
        if (rd != 0)
            check_val("link o_result", o_result, pc + 64'd4);
    endtask

    task automatic test_reset();
        // a valid addi sits at the input the whole time, reset has priority
        i_valid = 1'b1;
        i_inst  = enc_i(12'h7ff, F3_ADD_SUB, 5'd1, OP_IMM);
        i_pc    = rand_pc();
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_ctrl(1'b0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0);
            check_val("o_pc", o_pc, 64'h0);
        end
        reset = 1'b0;
        step(enc_i(12'h7ff, F3_ADD_SUB, 5'd1, OP_IMM), 64'h0, 64'h0, 64'h0, 1'b0, 1'b0);
        check_ctrl(1'b0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0);
        check_val("o_pc", o_pc, 64'h0);
    endtask

    task automatic test_int_ops(logic word);
        funct3_t     f3;
        logic        alt;
        logic [31:0] r;
        logic [11:0] imm;
        reg_idx_t    rd;
        xlen_t       a;
        xlen_t       b;
        addr_t       pc;
        for (int f = 0; f < 8; f++) begin
            f3 = funct3_t'(f);
            if (word && !(f3 == F3_ADD_SUB || f3 == F3_SLL || f3 == F3_SRL_SRA))
                continue;
            r   = lcg_next();
            rd  = r[4:0];
            a   = rand64();
            b   = rand64();
            pc  = rand_pc();
            alt = (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && r[5];
            step(enc_r(alt ? F7_ALT : F7_BASE, f3, rd, word ? OP_32 : OP), pc, a, b, 1'b1, 1'b0);
            check_write("reg-reg", rd, ref_alu(f3, alt, word, a, b), pc);
            alt = (f3 == F3_SRL_SRA) && r[6];   // srai and sraiw only
            if (f3 == F3_SLL || f3 == F3_SRL_SRA)
                imm = {1'b0, alt, 4'b0, word ? {1'b0, r[12:8]} : r[13:8]};
            else
                imm = r[31:20];
            step(enc_i(imm, f3, rd, word ? OP_IMM_32 : OP_IMM), pc, a, b, 1'b1, 1'b0);
            check_write("reg-imm", rd, ref_alu(f3, alt, word, a, sext(imm, 12)), pc);
        end
    endtask

    task automatic test_mul_upper();
        logic [127:0] prod;
        logic [31:0]  r;
        reg_idx_t     rd;
        xlen_t        a;
        xlen_t        b;
        xlen_t        u_imm;
        addr_t        pc;
        r     = lcg_next();
        rd    = r[4:0];
        a     = rand64();
        b     = rand64();
        pc    = rand_pc();
        u_imm = sext({r[31:12], 12'b0}, 32);
        prod  = a * b;
        step(enc_r(F7_MULDIV, F3_MUL, rd, OP), pc, a, b, 1'b1, 1'b0);
        check_write("mul", rd, prod[63:0], pc);
        prod = a[31:0] * b[31:0];
        step(enc_r(F7_MULDIV, F3_MUL, rd, OP_32), pc, a, b, 1'b1, 1'b0);
        check_write("mulw", rd, sext(prod[31:0], 32), pc);
        step({r[31:12], rd, LUI}, pc, a, b, 1'b1, 1'b0);
        check_write("lui", rd, u_imm, pc);
        step({r[31:12], rd, AUIPC}, pc, a, b, 1'b1, 1'b0);
        check_write("auipc", rd, pc + u_imm, pc);
    endtask

    task automatic test_jumps();
        funct3_t     f3;
        logic [31:0] r;
        logic [12:0] b_imm;
        logic        taken;
        reg_idx_t    rd;
        xlen_t       a;
        xlen_t       b;
        addr_t       pc;
        for (int f = 0; f < 8; f++) begin
            f3 = funct3_t'(f);
            if (f3 == 3'b010 || f3 == 3'b011)
                continue;   // not branch codes
            r     = lcg_next();
            a     = rand64();
            b     = (r[1:0] == 2'b00) ? a : rand64();
            b_imm = {r[31:20], 1'b0};
            pc    = rand_pc();
            taken = ref_branch(f3, a, b);
            step(enc_b(b_imm, f3), pc, a, b, 1'b1, 1'b0);
            check_ctrl(1'b0, 5'd0, 1'b0, 1'b0, taken, 1'b0);
            if (taken)
                check_val("o_jmp_target", o_jmp_target, pc + sext(b_imm, 13));
        end
        r  = lcg_next();
        rd = r[4:0];
        pc = rand_pc();
        step(enc_j({r[31:12], 1'b0}, rd), pc, a, b, 1'b1, 1'b0);
        check_jump(rd, pc + sext({r[31:12], 1'b0}, 21), pc);
        a = rand64();   // odd bases are fine, bit 0 is dropped
        step(enc_i(r[11:0], 3'b000, rd, JALR), pc, a, b, 1'b1, 1'b0);
        check_jump(rd, (a + sext(r[11:0], 12)) & ~64'h1, pc);
    endtask

    task automatic test_mem();
        funct3_t     f3;
        logic [31:0] r;
        reg_idx_t    rd;
        xlen_t       a;
        xlen_t       b;
        addr_t       pc;
        for (int f = 0; f < 7; f++) begin
            f3 = funct3_t'(f);
            r  = lcg_next();
            rd = r[4:0];
            a  = rand64();
            b  = rand64();
            pc = rand_pc();
            step(enc_i(r[31:20], f3, rd, LOAD), pc, a, b, 1'b1, 1'b0);
            check_ctrl(rd != 0, rd, 1'b1, 1'b0, 1'b0, 1'b0);   // rd rides along for the load
            check_val("o_mem_addr", o_mem_addr, a + sext(r[31:20], 12));
            check_val("o_mem_size", o_mem_size, f3[1:0]);
            if (f < 4) begin
                step(enc_s(r[31:20], f3), pc, a, b, 1'b1, 1'b0);
                check_ctrl(1'b0, 5'd0, 1'b0, 1'b1, 1'b0, 1'b0);
                check_val("o_mem_addr", o_mem_addr, a + sext(r[31:20], 12));
                check_val("o_mem_size", o_mem_size, f3[1:0]);
                check_val("o_store_data", o_store_data, b & (~64'h0 >> (64 - (8 << f))));
            end
        end
    endtask

    task automatic test_flush_ecall();
        word_t insts [5];
        xlen_t a;
        addr_t pc;
        a  = rand64();
        pc = rand_pc();
        step(ECALL_INST, pc, a, a, 1'b1, 1'b0);
        check_ctrl(1'b0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b1);
        check_val("o_pc", o_pc, pc);
        // every one of these would raise a control output if it went through
        insts = '{enc_i(12'h123, F3_ADD_SUB, 5'd5, OP_IMM), enc_j(21'h800, 5'd1),
                  enc_s(12'h010, F3_SW), enc_b(13'h040, F3_BEQ), ECALL_INST};
        foreach (insts[k]) begin
            step(insts[k], pc, a, a, 1'b1, 1'b1);
            check_ctrl(1'b0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0);
            step(insts[k], pc, a, a, 1'b0, 1'b0);
            check_ctrl(1'b0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0);
        end
    endtask

    initial begin
        reset       = 1'b1;
        i_valid     = 1'b0;
        i_flush     = 1'b0;
        i_inst      = '0;
        i_pc        = '0;
        i_rs1_value = '0;
        i_rs2_value = '0;
        test_reset();
        for (int n = 0; n < N_ITER; n++) begin
            test_int_ops(1'b0);
            test_int_ops(1'b1);
            test_mul_upper();
            test_jumps();
            test_mem();
        end
        test_flush_ecall();
        i_valid = 1'b0;
        repeat (2) @(posedge clk);
        $display("checks %0d, check errors %0d, assertion failures %0d", checks, errors,
                 i_exec_stage.i_exec_stage_checker.fail_count);
        if (errors == 0 && i_exec_stage.i_exec_stage_checker.fail_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
source/rv_isa_pkg.sv
source/exec_pkg.sv
source/exec_bus_if.sv
source/exec_control.sv
source/int_alu.sv
source/branch_unit.sv
source/mem_agu.sv
source/exec_stage.sv
dv/exec_stage_checker.sv
dv/exec_stage_tb.sv

/* Bender.yml */
package:
  name: exec_stage

sources:
  - files:
      - source/rv_isa_pkg.sv
      - source/exec_pkg.sv
      - source/exec_bus_if.sv
      - source/exec_control.sv
      - source/int_alu.sv
      - source/branch_unit.sv
      - source/mem_agu.sv
      - source/exec_stage.sv
  - target: test
    files:
      - dv/exec_stage_checker.sv
      - dv/exec_stage_tb.sv
